//--- Makefile
# Verilator build and run for the pc unit testbench.

VERILATOR ?= verilator
TOP       ?= tb_pc_unit
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BINARY): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BINARY)
	./$(BINARY) 2>&1 | tee $(LOG)
	@if grep -q "Verification failed" $(LOG); then \
		echo "simulation reported a failure"; exit 1; \
	elif ! grep -q "Verification passed" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- hdl/branch_control.sv
`default_nettype none

module branch_control
	import isa_pkg::*, fetch_pkg::*;
(
	input  wire logic  reset,
	input  wire logic  clock,
	branch_if.ctrl     bus,
	output logic       do_link
);

	always_comb begin
		bus.pc_sel   = SEL_SEQ;
		bus.redirect = RD_NONE;
		do_link      = 1'b0;
		case (bus.opcode)
			TY_B: begin
				if ((bus.sub_op_b == BEQ) && bus.reg_rt_ra_equal) begin
					bus.pc_sel   = SEL_IMM14;
					bus.redirect = RD_BRANCH;
				end else if ((bus.sub_op_b == BNE) && !bus.reg_rt_ra_equal) begin
					bus.pc_sel   = SEL_IMM14;
					bus.redirect = RD_BRANCH;
				end
			end
			TY_J: begin
				bus.pc_sel = SEL_IMM24;
				if (bus.sub_op_j == JAL) begin
					do_link      = 1'b1; // link only for jal.
					bus.redirect = RD_JUMP_LINK;
				end else begin
					bus.redirect = RD_JUMP;
				end
			end
			JR: begin
				bus.pc_sel   = SEL_REG;
				bus.redirect = RD_JUMP_REG;
			end
			default: begin
				bus.pc_sel   = SEL_SEQ; // fall through to next word.
				bus.redirect = RD_NONE;
			end
		endcase
	end

	// any redirect kills the instruction behind it.
	assign bus.do_flush = (bus.pc_sel != SEL_SEQ);

	// a link only comes with a flushing jump.
	a_link_flush: assert property (@(posedge clock) disable iff (reset)
		do_link |-> (bus.do_flush && bus.redirect == RD_JUMP_LINK))
		else $error("do_link raised without a flushing jal");

	a_sel_known: assert property (@(posedge clock) disable iff (reset)
		!$isunknown(bus.pc_sel))
		else $error("pc_sel is unknown");

endmodule

`default_nettype wire

//--- hdl/branch_if.sv
`default_nettype none

interface branch_if
	import isa_pkg::*, fetch_pkg::*;
#(
	parameter int DATA_WIDTH = 32
) ();
	opcode_t                opcode;
	logic                   sub_op_b;
	logic                   sub_op_j;
	logic                   reg_rt_ra_equal;
	logic [IMM14_W-1:0]     imm_14bit;
	logic [IMM24_W-1:0]     imm_24bit;
	logic [DATA_WIDTH-1:0]  reg_rb_data;

	pc_sel_e   pc_sel;
	logic      do_flush;
	redirect_e redirect;

	modport ctrl (input opcode, sub_op_b, sub_op_j, reg_rt_ra_equal,
		output pc_sel, do_flush, redirect);
	modport dp (input pc_sel, imm_14bit, imm_24bit, reg_rb_data);
endinterface

`default_nettype wire

//--- hdl/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

	// next pc source.
	typedef enum logic [1:0] {
		SEL_SEQ   = 2'd0,
		SEL_IMM14 = 2'd1,
		SEL_IMM24 = 2'd2,
		SEL_REG   = 2'd3
	} pc_sel_e;

	// kind of redirect taken in fetch.
	typedef enum logic [2:0] {
		RD_NONE      = 3'd0,
		RD_BRANCH    = 3'd1,
		RD_JUMP      = 3'd2,
		RD_JUMP_LINK = 3'd3,
		RD_JUMP_REG  = 3'd4
	} redirect_e;

endpackage

`default_nettype wire

//--- hdl/isa_pkg.sv
`default_nettype none

package isa_pkg;

	// branch-class opcodes.
	typedef logic [5:0] opcode_t;

	localparam opcode_t TY_B = 6'b100110;
	localparam opcode_t TY_J = 6'b100100;
	localparam opcode_t JR   = 6'b100101;

	// sub_op_b values.
	localparam logic BEQ = 1'b0;
	localparam logic BNE = 1'b1;

	// sub_op_j values.
	localparam logic JJ  = 1'b0;
	localparam logic JAL = 1'b1;

	// immediate field widths.
	localparam int IMM14_W = 14;
	localparam int IMM24_W = 24;

endpackage

`default_nettype wire

//--- hdl/pc_datapath.sv
`default_nettype none

module pc_datapath
	import isa_pkg::*, fetch_pkg::*;
#(
	parameter int PC_WIDTH = 10
) (
	input  wire logic                 clock,
	input  wire logic                 reset,
	input  wire logic                 enable_pc,
	input  wire logic                 do_hazard,
	branch_if.dp                      bus,
	output logic [PC_WIDTH-1:0]       current_pc,
	output logic [PC_WIDTH-1:0]       next_pc
);

	localparam int OFF_W = 10;

	logic signed [OFF_W-1:0] off14;
	logic signed [OFF_W-1:0] off24;
	logic [PC_WIDTH-1:0]     inst_pc;

	// sign bit, low byte, and a zero lsb.
	assign off14 = {bus.imm_14bit[IMM14_W-1], bus.imm_14bit[7:0], 1'b0};
	assign off24 = {bus.imm_24bit[IMM24_W-1], bus.imm_24bit[7:0], 1'b0};

	// address of the instruction now in fetch.
	assign inst_pc = current_pc - PC_WIDTH'(4);

	always_comb begin
		case (bus.pc_sel)
			SEL_SEQ:   next_pc = current_pc + PC_WIDTH'(4);
			SEL_IMM14: next_pc = inst_pc + PC_WIDTH'(off14); // sign extends.
			SEL_IMM24: next_pc = inst_pc + PC_WIDTH'(off24);
			SEL_REG:   next_pc = bus.reg_rb_data[PC_WIDTH-1:0];
			default:   next_pc = current_pc + PC_WIDTH'(4);
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			current_pc <= '0;
		end else if (do_hazard) begin
			current_pc <= current_pc; // stall wins over enable.
		end else if (enable_pc) begin
			current_pc <= next_pc;
		end
	end

	a_pc_even: assert property (@(posedge clock) disable iff (reset)
		current_pc[0] == 1'b0)
		else $error("current_pc is not halfword aligned");

endmodule

`default_nettype wire

//--- hdl/pc_unit_top.sv
`default_nettype none

module pc_unit_top
	import isa_pkg::*, fetch_pkg::*;
#(
	parameter int PC_WIDTH   = 10,
	parameter int DATA_WIDTH = 32
) (
	input  wire logic                   clock,
	input  wire logic                   reset,
	input  wire logic                   enable_pc,
	input  wire logic                   do_hazard,
	input  wire opcode_t                opcode,
	input  wire logic                   sub_op_b,
	input  wire logic                   sub_op_j,
	input  wire logic                   reg_rt_ra_equal,
	input  wire logic [IMM14_W-1:0]     imm_14bit,
	input  wire logic [IMM24_W-1:0]     imm_24bit,
	input  wire logic [DATA_WIDTH-1:0]  reg_rb_data,
	output logic [PC_WIDTH-1:0]         current_pc,
	output logic                        do_link,
	output logic                        do_flush_reg1,
	output logic [PC_WIDTH-1:0]         if_pc,
	output logic                        if_valid,
	output redirect_e                   redirect_kind
);

	branch_if #(.DATA_WIDTH(DATA_WIDTH)) bus ();

	assign bus.opcode          = opcode;
	assign bus.sub_op_b        = sub_op_b;
	assign bus.sub_op_j        = sub_op_j;
	assign bus.reg_rt_ra_equal = reg_rt_ra_equal;
	assign bus.imm_14bit       = imm_14bit;
	assign bus.imm_24bit       = imm_24bit;
	assign bus.reg_rb_data     = reg_rb_data;
	assign do_flush_reg1       = bus.do_flush;

	branch_control u_ctrl (.reset(reset), .clock(clock), .bus(bus.ctrl), .do_link(do_link));

	pc_datapath #(.PC_WIDTH(PC_WIDTH)) u_dp (
		.clock(clock), .reset(reset), .enable_pc(enable_pc), .do_hazard(do_hazard),
		.bus(bus.dp), .current_pc(current_pc), .next_pc());

	// fetch address into decode.
	stage_reg #(.payload_t(logic [PC_WIDTH-1:0]), .BUBBLE('0)) u_reg1_pc (
		.clock(clock), .reset(reset), .hold(do_hazard), .flush(bus.do_flush),
		.d_valid(enable_pc), .d(current_pc), .q_valid(if_valid), .q(if_pc));

	stage_reg #(.payload_t(redirect_e), .BUBBLE(RD_NONE), .KEEP_ON_FLUSH(1'b1)) u_reg1_rd (
		.clock(clock), .reset(reset), .hold(do_hazard), .flush(bus.do_flush),
		.d_valid(enable_pc), .d(bus.redirect), .q_valid(), .q(redirect_kind));

endmodule

`default_nettype wire

//--- hdl/stage_reg.sv
`default_nettype none

module stage_reg #(
	parameter type      payload_t     = logic,
	parameter payload_t BUBBLE        = payload_t'(0),
	parameter bit       KEEP_ON_FLUSH = 1'b0
) (
	input  wire logic   clock,
	input  wire logic   reset,
	input  wire logic   hold,
	input  wire logic   flush,
	input  wire logic   d_valid,
	input  wire payload_t d,
	output logic        q_valid,
	output payload_t    q
);

	always_ff @(posedge clock) begin
		if (reset) begin
			q_valid <= 1'b0;
			q       <= BUBBLE;
		end else if (!hold) begin
			if (flush) begin
				q_valid <= 1'b0;
				// redirect kind survives the flush.
				q       <= KEEP_ON_FLUSH ? d : BUBBLE;
			end else begin
				q_valid <= d_valid;
				q       <= d;
			end
		end
	end

endmodule

`default_nettype wire

//--- src.f
hdl/isa_pkg.sv
hdl/fetch_pkg.sv
hdl/branch_if.sv
hdl/branch_control.sv
hdl/pc_datapath.sv
hdl/stage_reg.sv
hdl/pc_unit_top.sv
verification/tb_pc_unit.sv

//--- verification/tb_pc_unit.sv
`default_nettype none

module tb_pc_unit
	import isa_pkg::*, fetch_pkg::*;
();
	localparam int PC_WIDTH     = 10;
	localparam int DATA_WIDTH   = 32;
	localparam int EDGE_LIMIT   = 8; // clock changes allowed per wait.
	localparam int RUN_LIMIT    = 4000;

	typedef struct packed {
		opcode_t               opcode;
		logic                  sub_op_b;
		logic                  sub_op_j;
		logic                  equal;
		logic [IMM14_W-1:0]    imm14;
		logic [IMM24_W-1:0]    imm24;
		logic [DATA_WIDTH-1:0] rb;
		logic                  enable;
		logic                  hazard;
	} row_t;

	logic                  clock;
	logic                  reset;
	logic                  enable_pc;
	logic                  do_hazard;
	opcode_t               opcode;
	logic                  sub_op_b;
	logic                  sub_op_j;
	logic                  reg_rt_ra_equal;
	logic [IMM14_W-1:0]    imm_14bit;
	logic [IMM24_W-1:0]    imm_24bit;
	logic [DATA_WIDTH-1:0] reg_rb_data;
	logic [PC_WIDTH-1:0]   current_pc;
	logic                  do_link;
	logic                  do_flush_reg1;
	logic [PC_WIDTH-1:0]   if_pc;
	logic                  if_valid;
	redirect_e             redirect_kind;

	row_t  table_rows[$];
	string table_names[$];
	int    error_count;
	int    check_count;
	int    test_count;
	int    test_fail_count;

	// reference model state.
	logic [PC_WIDTH-1:0] m_pc;
	logic [PC_WIDTH-1:0] m_if_pc;
	logic                m_if_valid;
	redirect_e           m_rd;

	pc_unit_top #(.PC_WIDTH(PC_WIDTH), .DATA_WIDTH(DATA_WIDTH)) uut (
		.clock(clock), .reset(reset), .enable_pc(enable_pc), .do_hazard(do_hazard),
		.opcode(opcode), .sub_op_b(sub_op_b), .sub_op_j(sub_op_j),
		.reg_rt_ra_equal(reg_rt_ra_equal), .imm_14bit(imm_14bit), .imm_24bit(imm_24bit),
		.reg_rb_data(reg_rb_data), .current_pc(current_pc), .do_link(do_link),
		.do_flush_reg1(do_flush_reg1), .if_pc(if_pc), .if_valid(if_valid),
		.redirect_kind(redirect_kind));

	always #2 clock = ~clock;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Verification failed");
		$finish;
	endtask

	initial begin
		#(RUN_LIMIT);
		abort_run("simulation ran past its time limit");
	end

	task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("ERROR t=%0t %s: got %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic wait_edge(input logic level);
		int changes;
		changes = 0;
		do begin
			@(clock);
			changes++;
		end while (clock !== level && changes < EDGE_LIMIT);
		if (clock !== level)
			abort_run("clock edge did not arrive within the wait limit");
	endtask

	// decode rules for the branch class.
	function automatic redirect_e expected_redirect(input row_t r);
		if (r.opcode == TY_B) begin
			if (r.sub_op_b == BEQ && r.equal)
				return RD_BRANCH;
			if (r.sub_op_b == BNE && !r.equal)
				return RD_BRANCH;
			return RD_NONE;
		end
		if (r.opcode == TY_J)
			return (r.sub_op_j == JAL) ? RD_JUMP_LINK : RD_JUMP;
		if (r.opcode == JR)
			return RD_JUMP_REG;
		return RD_NONE;
	endfunction

	// instruction address plus the 10-bit signed offset.
	function automatic logic [PC_WIDTH-1:0] branch_target(input logic [PC_WIDTH-1:0] pc,
			input logic [IMM24_W-1:0] imm, input int top);
		int offset;
		offset = int'(imm[7:0]) * 2;
		if (imm[top])
			offset = offset - 512;
		return PC_WIDTH'(int'(pc) - 4 + offset);
	endfunction

	function automatic logic [PC_WIDTH-1:0] expected_next(input row_t r,
			input logic [PC_WIDTH-1:0] pc);
		case (expected_redirect(r))
			RD_BRANCH:             return branch_target(pc, IMM24_W'(r.imm14), IMM14_W - 1);
			RD_JUMP, RD_JUMP_LINK: return branch_target(pc, r.imm24, IMM24_W - 1);
			RD_JUMP_REG:           return r.rb[PC_WIDTH-1:0];
			default:               return PC_WIDTH'(int'(pc) + 4);
		endcase
	endfunction

	function automatic row_t make_row(input opcode_t op, input logic sb, input logic sj,
			input logic eq, input logic en, input logic hz);
		row_t r;
		r.opcode   = op;
		r.sub_op_b = sb;
		r.sub_op_j = sj;
		r.equal    = eq;
		r.imm14    = IMM14_W'($urandom);
		r.imm24    = IMM24_W'($urandom);
		r.rb       = DATA_WIDTH'($urandom & 32'hffff_fffe); // pc stays even.
		r.enable   = en;
		r.hazard   = hz;
		return r;
	endfunction

	task automatic push_row(input string name, input row_t r);
		table_rows.push_back(r);
		table_names.push_back(name);
	endtask

	task automatic build_table();
		opcode_t picks[4];
		row_t    r;
		picks = '{6'h00, TY_B, TY_J, JR};
		for (int i = 0; i < 4; i++)
			push_row($sformatf("sequential %0d", i), make_row(6'h00, 0, 0, 0, 1, 0));
		push_row("beq taken", make_row(TY_B, BEQ, 0, 1, 1, 0));
		push_row("after beq", make_row(6'h00, 0, 0, 0, 1, 0));
		push_row("beq not taken", make_row(TY_B, BEQ, 0, 0, 1, 0));
		r = make_row(TY_B, BNE, 0, 0, 1, 0);
		r.imm14[IMM14_W-1] = 1'b1; // backward branch.
		push_row("bne taken backward", r);
		push_row("bne not taken", make_row(TY_B, BNE, 0, 1, 1, 0));
		push_row("after bne", make_row(6'h00, 0, 0, 0, 1, 0));
		push_row("j", make_row(TY_J, 0, JJ, 0, 1, 0));
		push_row("jal", make_row(TY_J, 0, JAL, 0, 1, 0));
		push_row("after jal", make_row(6'h00, 0, 0, 0, 1, 0));
		push_row("jr", make_row(JR, 0, 0, 0, 1, 0));
		push_row("after jr", make_row(6'h00, 0, 0, 0, 1, 0));
		push_row("hazard with enable", make_row(6'h00, 0, 0, 0, 1, 1));
		push_row("hazard with beq", make_row(TY_B, BEQ, 0, 1, 1, 1));
		push_row("enable low", make_row(6'h00, 0, 0, 0, 0, 0));
		push_row("resume", make_row(6'h00, 0, 0, 0, 1, 0));
		for (int i = 0; i < 10; i++) begin
			r = make_row(picks[$urandom_range(0, 3)], 1'($urandom_range(0, 1)),
				1'($urandom_range(0, 1)), 1'($urandom_range(0, 1)),
				1'($urandom_range(0, 1)), 1'($urandom_range(0, 3) == 0));
			push_row($sformatf("random %0d", i), r);
		end
	endtask

	task automatic drive(input row_t r);
		opcode          = r.opcode;
		sub_op_b        = r.sub_op_b;
		sub_op_j        = r.sub_op_j;
		reg_rt_ra_equal = r.equal;
		imm_14bit       = r.imm14;
		imm_24bit       = r.imm24;
		reg_rb_data     = r.rb;
		enable_pc       = r.enable;
		do_hazard       = r.hazard;
	endtask

	task automatic finish_test(input string name, input int errors_before);
		test_count++;
		if (error_count == errors_before) begin
			$display("test %s ok", name);
		end else begin
			test_fail_count++;
			$display("test %s FAILED", name);
		end
	endtask

	task automatic apply_row(input row_t r, input string name);
		redirect_e           rd;
		logic [PC_WIDTH-1:0] pc_next;
		int                  errors_before;
		errors_before = error_count;
		wait_edge(1'b0);
		drive(r);
		#1;
		rd      = expected_redirect(r);
		pc_next = expected_next(r, m_pc);
		check({name, " do_link"}, 32'(do_link), 32'(rd == RD_JUMP_LINK));
		check({name, " do_flush_reg1"}, 32'(do_flush_reg1), 32'(rd != RD_NONE));
		if (!r.hazard) begin
			if (rd != RD_NONE) begin
				m_if_valid = 1'b0; // flushed into a bubble.
				m_if_pc    = '0;
			end else begin
				m_if_valid = r.enable;
				m_if_pc    = m_pc;
			end
			m_rd = rd;
			if (r.enable)
				m_pc = pc_next;
		end
		wait_edge(1'b1);
		#1;
		check({name, " current_pc"}, 32'(current_pc), 32'(m_pc));
		check({name, " if_pc"}, 32'(if_pc), 32'(m_if_pc));
		check({name, " if_valid"}, 32'(if_valid), 32'(m_if_valid));
		check({name, " redirect_kind"}, 32'(redirect_kind), 32'(m_rd));
		finish_test(name, errors_before);
	endtask

	initial begin
		int errors_before;
		void'($urandom(32'hb509_c4ac));
		clock           = 1'b0;
		reset           = 1'b1;
		enable_pc       = 1'b0;
		do_hazard       = 1'b0;
		opcode          = '0;
		sub_op_b        = 1'b0;
		sub_op_j        = 1'b0;
		reg_rt_ra_equal = 1'b0;
		imm_14bit       = '0;
		imm_24bit       = '0;
		reg_rb_data     = '0;
		error_count     = 0;
		check_count     = 0;
		test_count      = 0;
		test_fail_count = 0;
		build_table();
		repeat (3) wait_edge(1'b1);
		wait_edge(1'b0);
		reset = 1'b0;
		errors_before = error_count;
		check("reset current_pc", 32'(current_pc), 32'h0);
		check("reset if_valid", 32'(if_valid), 32'h0);
		check("reset redirect_kind", 32'(redirect_kind), 32'(RD_NONE));
		check("reset do_link", 32'(do_link), 32'h0);
		check("reset do_flush_reg1", 32'(do_flush_reg1), 32'h0);
		finish_test("reset", errors_before);
		m_pc       = '0;
		m_if_pc    = '0;
		m_if_valid = 1'b0;
		m_rd       = RD_NONE;
		for (int i = 0; i < table_rows.size(); i++)
			apply_row(table_rows[i], table_names[i]);
		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			test_count, test_fail_count, check_count, error_count);
		if (error_count == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire
